/* flist.f */
hdl/dpPkg.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/forwardUnit.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/coreDatapath.sv
dv/coreDatapath_assert.sv
dv/tbCoreDatapath.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tbCoreDatapath
FLIST      := flist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/tbCoreDatapath.sv */
`timescale 1ns/1ps

module tbCoreDatapath;

  localparam int clkPeriod   = 4;
  localparam int resetCycles = 5;
  localparam int numInstr    = 2000;
  localparam int drainCycles = 6;  // Pipeline depth plus slack
  localparam int watchdogNs  = (resetCycles + numInstr + drainCycles + 1) * clkPeriod + 400;

  typedef struct packed {
    int             due;    // Edge after which the retire shows
    dpPkg::regAddrT rd;
    dpPkg::wordT    value;
  } retireEntT;

  logic           clk;
  logic           rst;
  logic           instrValid;
  dpPkg::wordT    instr;
  logic           retireValid;
  dpPkg::regAddrT retireRd;
  dpPkg::wordT    retireValue;
  dpPkg::flagsT   flags;

  integer         seed;
  int             edgeCnt;          // Rising edges seen so far
  dpPkg::wordT    modelRegs [16];
  dpPkg::flagsT   modelFlags;
  retireEntT      retireQ [$];      // Expected retires, oldest first
  dpPkg::flagsT   flagsQ [$];       // Model NZCV of the last three issue slots

  coreDatapath i_coreDatapath (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instr       (instr),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireValue (retireValue),
    .flags       (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkWord(input string name, input dpPkg::wordT got, input dpPkg::wordT exp);
    if (got !== exp) begin
      failRun($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic checkReg(input string name, input dpPkg::regAddrT got,
                          input dpPkg::regAddrT exp);
    if (got !== exp) begin
      failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkFlags(input string name, input dpPkg::flagsT got, input dpPkg::flagsT exp);
    if (got !== exp) begin
      failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Shift one bit position per step
  function automatic dpPkg::wordT shiftModel(input dpPkg::wordT x, input logic [1:0] kind,
                                             input logic [4:0] amt);
    dpPkg::wordT r;
    r = x;
    for (int i = 0; i < int'(amt); i++) begin
      case (kind)
        2'b00:   r = {r[30:0], 1'b0};    // LSL
        2'b01:   r = {1'b0, r[31:1]};    // LSR
        2'b10:   r = {r[31], r[31:1]};   // ASR keeps the sign
        default: r = {r[0], r[31:1]};    // ROR
      endcase
    end
    return r;
  endfunction

  // Architectural execution in program order
  task automatic modelIssue(input dpPkg::wordT w, input int dueEdge);
    dpPkg::wordT a;
    dpPkg::wordT b;
    dpPkg::wordT res;
    logic [32:0] wide;
    logic        c;
    logic        v;
    logic        writes;
    logic        nop;
    retireEntT   ent;
    a      = modelRegs[w[19:16]];
    b      = w[25] ? {24'h0, w[7:0]} : shiftModel(modelRegs[w[3:0]], w[6:5], w[11:7]);
    c      = modelFlags[1];  // Logic ops keep C and V
    v      = modelFlags[0];
    writes = 1'b1;
    nop    = 1'b0;
    res    = '0;
    case (w[24:21])
      dpPkg::opAdd, dpPkg::opCmn: begin
        wide   = {1'b0, a} + {1'b0, b};
        res    = wide[31:0];
        c      = wide[32];
        v      = (a[31] == b[31]) && (res[31] != a[31]);
        writes = (w[24:21] == dpPkg::opAdd);
      end
      dpPkg::opSub, dpPkg::opCmp: begin
        res    = a - b;
        c      = (a >= b);  // No borrow
        v      = (a[31] != b[31]) && (res[31] != a[31]);
        writes = (w[24:21] == dpPkg::opSub);
      end
      dpPkg::opRsb: begin
        res = b - a;
        c   = (b >= a);
        v   = (a[31] != b[31]) && (res[31] != b[31]);
      end
      dpPkg::opAnd: res = a & b;
      dpPkg::opEor: res = a ^ b;
      dpPkg::opOrr: res = a | b;
      dpPkg::opMov: res = b;
      dpPkg::opBic: res = a & ~b;
      dpPkg::opMvn: res = ~b;
      default: begin
        writes = 1'b0;
        nop    = 1'b1;
      end
    endcase
    if (w[20] && !nop) begin
      modelFlags = {res[31], res == '0, c, v};
    end
    if (writes) begin
      modelRegs[w[15:12]] = res;
      ent.due   = dueEdge;
      ent.rd    = w[15:12];
      ent.value = res;
      retireQ.push_back(ent);
    end
  endtask

  task automatic issueNext();
    logic [31:0] r;
    dpPkg::wordT w;
    r         = $random(seed);
    w         = $random(seed);
    w[19:18]  = 2'b00;  // rn in R0..R3 for dense hazards
    w[15:14]  = 2'b00;  // rd
    if (!w[25]) begin
      w[3:2] = 2'b00;   // rm, imm8 keeps all its bits
    end
    instrValid = ((r % 32'd5) != 32'd0);  // About one bubble in five
    instr      = w;
    if (instrValid) begin
      modelIssue(w, edgeCnt + 4);  // Captured next edge, retires three later
    end
    flagsQ.push_back(modelFlags);
  endtask

  task automatic driveBubble();
    instrValid = 1'b0;
    flagsQ.push_back(modelFlags);
  endtask

  task automatic sampleOutputs();
    retireEntT    exp;
    dpPkg::flagsT expFlags;
    expFlags = flagsQ.pop_front();  // State three slots back
    checkFlags("flags", flags, expFlags);
    if (retireValid === 1'b1) begin
      if (retireQ.size() == 0) begin
        failRun("Retire seen while no instruction was expected to retire");
      end else begin
        exp = retireQ.pop_front();
        if (exp.due != edgeCnt) begin
          failRun($sformatf("Retire after edge %0d was due after edge %0d", edgeCnt, exp.due));
        end
        checkReg("retireRd", retireRd, exp.rd);
        checkWord("retireValue", retireValue, exp.value);
      end
    end else if (retireValid !== 1'b0) begin
      failRun("retireValid is unknown");
    end else if (retireQ.size() != 0 && retireQ[0].due == edgeCnt) begin
      failRun($sformatf("Expected retire after edge %0d did not appear", edgeCnt));
    end
  endtask

  initial begin
    seed       = 32'h86ef_2196;
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    modelFlags = '0;
    edgeCnt    = 0;
    for (int i = 0; i < 16; i++) begin
      modelRegs[i] = '0;
    end
    repeat (3) flagsQ.push_back(4'h0);  // Reset value in flight
    repeat (resetCycles) @(posedge clk);
    #1;
    rst     = 1'b0;
    edgeCnt = resetCycles;
    for (int n = 0; n < numInstr + drainCycles; n++) begin
      sampleOutputs();
      if (n < numInstr) begin
        issueNext();
      end else begin
        driveBubble();
      end
      @(posedge clk);
      #1;
      edgeCnt++;
    end
    sampleOutputs();
    if (retireQ.size() != 0) begin
      failRun($sformatf("%0d expected retires never appeared", retireQ.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

  initial begin
    #(watchdogNs);
    failRun("Watchdog timeout, the run did not complete in time");
  end

endmodule

/* dv/coreDatapath_assert.sv */
`timescale 1ns/1ps

module coreDatapathAssert (
  input logic         clk,
  input logic         rst,
  input logic         retireValid,
  input dpPkg::wordT  retireValue,
  input dpPkg::flagsT flags,
  input logic         decodeValid  // Enters execute on the next edge
);

  // Nothing retires right out of reset
  retireAfterReset: assert property (@(posedge clk) $fell(rst) |-> !retireValid)
    else $error("retireValid high in the first cycle after reset");

  retireKnown: assert property (@(posedge clk) disable iff (rst)
    retireValid |-> !$isunknown(retireValue))
    else $error("retireValue has unknown bits while retireValid is high");

  // Past decode valid is the execute slot, an empty slot keeps NZCV on the next edge
  flagsHold: assert property (@(posedge clk) disable iff (rst)
    !$past(decodeValid) |=> $stable(flags))
    else $error("flags changed with no instruction in execute");

endmodule

bind coreDatapath coreDatapathAssert i_coreDatapathAssert (
  .clk         (clk),
  .rst         (rst),
  .retireValid (retireValid),
  .retireValue (retireValue),
  .flags       (flags),
  .decodeValid (decodeRec.valid)
);

/* hdl/coreDatapath.sv */
`timescale 1ns/1ps

module coreDatapath (
  input  logic           clk,
  input  logic           rst,
  input  logic           instrValid,   // Low for a bubble
  input  dpPkg::wordT    instr,
  output logic           retireValid,
  output dpPkg::regAddrT retireRd,
  output dpPkg::wordT    retireValue,
  output dpPkg::flagsT   flags
);

  dpPkg::regAddrT   raddrA;
  dpPkg::regAddrT   raddrB;
  dpPkg::wordT      rdataA;
  dpPkg::wordT      rdataB;
  dpPkg::decodeRecT decodeRec;  // D to E
  dpPkg::resultRecT memRec;     // E to M
  dpPkg::resultRecT wbRec;      // M to W, also bypass source
  logic             we;
  dpPkg::regAddrT   waddr;
  dpPkg::wordT      wdata;

  regFile i_regFile (
    .clk    (clk),
    .rst    (rst),
    .raddrA (raddrA),
    .raddrB (raddrB),
    .rdataA (rdataA),
    .rdataB (rdataB),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  decodeStage i_decodeStage (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .raddrA     (raddrA),
    .raddrB     (raddrB),
    .rdataA     (rdataA),
    .rdataB     (rdataB),
    .decodeRec  (decodeRec)
  );

  executeStage i_executeStage (
    .clk       (clk),
    .rst       (rst),
    .decodeRec (decodeRec),
    .wbRec     (wbRec),
    .memRec    (memRec),
    .flags     (flags)
  );

  writebackStage i_writebackStage (
    .clk         (clk),
    .rst         (rst),
    .memRec      (memRec),
    .wbRec       (wbRec),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireValue (retireValue)
  );

endmodule

/* hdl/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
  input  logic             clk,
  input  logic             rst,
  input  dpPkg::resultRecT memRec,
  output dpPkg::resultRecT wbRec,        // W-stage register
  output logic             we,
  output dpPkg::regAddrT   waddr,
  output dpPkg::wordT      wdata,
  output logic             retireValid,
  output dpPkg::regAddrT   retireRd,
  output dpPkg::wordT      retireValue
);

  // M stage has no memory access, record just moves on to W
  always_ff @(posedge clk) begin
    if (rst) wbRec <= '0;
    else     wbRec <= memRec;
  end

  // Register write lands on the next edge
  assign we    = wbRec.valid && wbRec.writes;
  assign waddr = wbRec.rd;
  assign wdata = wbRec.value;

  // Compares and no-ops never retire
  assign retireValid = we;
  assign retireRd    = wbRec.rd;
  assign retireValue = wbRec.value;

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  dpPkg::decodeRecT decodeRec,
  input  dpPkg::resultRecT wbRec,
  output dpPkg::resultRecT memRec,   // M-stage register
  output dpPkg::flagsT     flags
);

  dpPkg::decodeRecT exRec;    // Execute register
  logic [1:0]       selA;
  logic [1:0]       selB;
  dpPkg::wordT      opA;      // rn after bypass
  dpPkg::wordT      rmVal;    // rm after bypass, before shift
  dpPkg::wordT      shifted;
  dpPkg::wordT      opB;
  logic [63:0]      rotPair;  // Doubled word for rotate
  dpPkg::wordT      addX;
  dpPkg::wordT      addY;
  logic             addCin;
  logic [32:0]      sum;
  logic             carry;
  logic             overflow;
  dpPkg::wordT      result;
  logic             isArith;
  logic             isWriting;
  logic             isNop;

  always_ff @(posedge clk) begin
    if (rst) exRec <= '0;
    else     exRec <= decodeRec;
  end

  forwardUnit i_forwardUnit (
    .srcA   (exRec.rn),
    .srcB   (exRec.rm),
    .memRec (memRec),
    .wbRec  (wbRec),
    .selA   (selA),
    .selB   (selB)
  );

  always_comb begin
    case (selA)
      dpPkg::fwdMem: opA = memRec.value;
      dpPkg::fwdWb:  opA = wbRec.value;
      default:       opA = exRec.rnData;
    endcase
    case (selB)
      dpPkg::fwdMem: rmVal = memRec.value;
      dpPkg::fwdWb:  rmVal = wbRec.value;
      default:       rmVal = exRec.rmData;
    endcase
  end

  // Barrel shifter, amount 0 passes rm unchanged for every type
  always_comb begin
    rotPair = {rmVal, rmVal} >> exRec.shamt;
    case (exRec.shType)
      dpPkg::shLsl: shifted = rmVal << exRec.shamt;
      dpPkg::shLsr: shifted = rmVal >> exRec.shamt;
      dpPkg::shAsr: shifted = dpPkg::wordT'($signed(rmVal) >>> exRec.shamt);
      default:      shifted = rotPair[31:0];  // ROR
    endcase
    opB = exRec.immSel ? exRec.imm : shifted;
  end

  // Single adder, subtraction as x + ~y + 1
  always_comb begin
    addX   = opA;
    addY   = opB;
    addCin = 1'b0;
    case (exRec.op)
      dpPkg::opSub, dpPkg::opCmp: begin
        addY   = ~opB;
        addCin = 1'b1;
      end
      dpPkg::opRsb: begin
        addX   = opB;  // Reverse operands
        addY   = ~opA;
        addCin = 1'b1;
      end
      default: ;
    endcase
    sum      = {1'b0, addX} + {1'b0, addY} + {32'b0, addCin};
    carry    = sum[32];  // Not-borrow for the subtracts
    overflow = (addX[31] == addY[31]) && (sum[31] != addX[31]);
  end

  always_comb begin
    isArith   = 1'b0;
    isWriting = 1'b1;
    isNop     = 1'b0;
    result    = sum[31:0];
    case (exRec.op)
      dpPkg::opAnd: result = opA & opB;
      dpPkg::opEor: result = opA ^ opB;
      dpPkg::opOrr: result = opA | opB;
      dpPkg::opMov: result = opB;
      dpPkg::opBic: result = opA & ~opB;
      dpPkg::opMvn: result = ~opB;
      dpPkg::opSub, dpPkg::opRsb, dpPkg::opAdd: isArith = 1'b1;
      dpPkg::opCmp, dpPkg::opCmn: begin
        isArith   = 1'b1;
        isWriting = 1'b0;  // Flags only
      end
      default: begin
        isWriting = 1'b0;
        isNop     = 1'b1;
      end
    endcase
  end

  // NZCV, logic ops keep C and V
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (exRec.valid && exRec.setFlags && !isNop) begin
      flags <= {result[31], result == '0,
                isArith ? carry : flags[1],
                isArith ? overflow : flags[0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memRec <= '0;
    end else begin
      memRec.valid  <= exRec.valid;
      memRec.writes <= exRec.valid && isWriting;
      memRec.rd     <= exRec.rd;
      memRec.value  <= result;
    end
  end

endmodule

/* hdl/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit (
  input  dpPkg::regAddrT   srcA,
  input  dpPkg::regAddrT   srcB,
  input  dpPkg::resultRecT memRec,
  input  dpPkg::resultRecT wbRec,
  output logic [1:0]       selA,
  output logic [1:0]       selB
);

  // Youngest producer wins, so M is tested before W
  function automatic logic [1:0] pickSrc(
    input dpPkg::regAddrT   src,
    input dpPkg::resultRecT mRec,
    input dpPkg::resultRecT wRec
  );
    logic [1:0] sel;
    if (mRec.valid && mRec.writes && (mRec.rd == src)) begin
      sel = dpPkg::fwdMem;
    end else if (wRec.valid && wRec.writes && (wRec.rd == src)) begin
      sel = dpPkg::fwdWb;
    end else begin
      sel = dpPkg::fwdRf;  // Older results already in the register file
    end
    return sel;
  endfunction

  always_comb begin
    selA = pickSrc(srcA, memRec, wbRec);
    selB = pickSrc(srcB, memRec, wbRec);
  end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             instrValid,
  input  dpPkg::wordT      instr,
  output dpPkg::regAddrT   raddrA,
  output dpPkg::regAddrT   raddrB,
  input  dpPkg::wordT      rdataA,
  input  dpPkg::wordT      rdataB,
  output dpPkg::decodeRecT decodeRec
);

  logic           instrValidQ;  // Bubble flag of the held instruction
  dpPkg::wordT    instrQ;       // Instruction register
  dpPkg::regAddrT rn;
  dpPkg::regAddrT rm;
  dpPkg::wordT    immExt;

  always_ff @(posedge clk) begin
    if (rst) begin
      instrValidQ <= 1'b0;
    end else begin
      instrValidQ <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    instrQ <= instr;  // Payload, qualified by instrValidQ
  end

  // Source fields
  assign rn     = instrQ[19:16];
  assign rm     = instrQ[3:0];   // Don't care in immediate form
  assign immExt = {24'b0, instrQ[7:0]};

  // Register file read happens this cycle
  assign raddrA = rn;
  assign raddrB = rm;

  always_comb begin
    decodeRec.valid    = instrValidQ;
    decodeRec.op       = dpPkg::aluOpT'(instrQ[24:21]);  // Unlisted codes kept as-is
    decodeRec.setFlags = instrQ[20];
    decodeRec.immSel   = instrQ[25];
    decodeRec.rn       = rn;
    decodeRec.rm       = rm;
    decodeRec.rd       = instrQ[15:12];
    decodeRec.shamt    = instrQ[11:7];
    decodeRec.shType   = dpPkg::shiftT'(instrQ[6:5]);
    decodeRec.rnData   = rdataA;
    decodeRec.rmData   = rdataB;
    decodeRec.imm      = immExt;
  end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic           clk,
  input  logic           rst,
  input  dpPkg::regAddrT raddrA,
  input  dpPkg::regAddrT raddrB,
  output dpPkg::wordT    rdataA,
  output dpPkg::wordT    rdataB,
  input  logic           we,
  input  dpPkg::regAddrT waddr,
  input  dpPkg::wordT    wdata
);

  dpPkg::wordT regs [16];  // Architectural registers

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through so decode sees the instruction three ahead of it
  assign rdataA = (we && (waddr == raddrA)) ? wdata : regs[raddrA];
  assign rdataB = (we && (waddr == raddrB)) ? wdata : regs[raddrB];

endmodule

/* hdl/dpPkg.sv */
package dpPkg;

  // Instruction word, data-processing class only
  //   [25]    immSel, operand 2 is an immediate
  //   [24:21] op
  //   [20]    setFlags
  //   [19:16] rn, first source
  //   [15:12] rd, destination
  //   Register form: [11:7] shamt, [6:5] shType, [3:0] rm
  //   Immediate form: [7:0] imm8, zero-extended
  // Bits 31:26 and bit 4 are ignored

  typedef logic [31:0] wordT;     // Data word
  typedef logic [3:0]  regAddrT;  // R0..R15, no PC special case
  typedef logic [4:0]  shamtT;    // Shift amount, 0 means no shift
  typedef logic [3:0]  flagsT;    // N Z C V, N in the msb

  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opCmp = 4'b1010,  // Flags only
    opCmn = 4'b1011,  // Flags only
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } aluOpT;           // Codes not listed behave as no-ops

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftT;

  // Bypass select encoding
  localparam logic [1:0] fwdRf  = 2'd0;  // Register file value
  localparam logic [1:0] fwdWb  = 2'd1;  // W-stage result
  localparam logic [1:0] fwdMem = 2'd2;  // M-stage result

  typedef struct packed {
    logic    valid;
    aluOpT   op;
    logic    setFlags;
    logic    immSel;
    regAddrT rn;
    regAddrT rm;
    regAddrT rd;
    shamtT   shamt;
    shiftT   shType;
    wordT    rnData;  // Read in decode, may be stale in execute
    wordT    rmData;
    wordT    imm;
  } decodeRecT;

  typedef struct packed {
    logic    valid;
    logic    writes;  // Result goes to rd
    regAddrT rd;
    wordT    value;
  } resultRecT;

endpackage
